// File: src.f
design/analog_pkg.sv
design/bus_pkg.sv
design/sys_bus_decoder.sv
design/adc_frontend.sv
design/dac_backend.sv
design/housekeeping_regs.sv
design/output_offset_regs.sv
design/analog_top.sv
test/tb_checker.sv
test/tb_analog_top.sv

// File: Makefile
# Verilator build of tb_analog_top; run passes only if the log holds the pass line

all: run

obj_dir/Vtb_analog_top: src.f $(shell cat src.f)
	verilator --binary --timing -Wno-fatal --top-module tb_analog_top \
	  -f src.f -o Vtb_analog_top

run: obj_dir/Vtb_analog_top
	./obj_dir/Vtb_analog_top | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: test/tb_analog_top.sv
// one 4 ns clock; bus transfers one at a time with the address held until ack, checker compares
`timescale 1ns/1ps

module tb_analog_top;

  localparam int SW = analog_pkg::SAMPLE_W;
  localparam int HK = bus_pkg::REGION_HK;
  localparam int OF = bus_pkg::REGION_OFFSET;

  // test lengths in cycles
  localparam int DP_ROUNDS   = 8;
  localparam int DP_CYCLES   = 100;
  localparam int SAT_CYCLES  = 60;
  localparam int LOOP_CYCLES = 260;
  localparam int BUS_OPS     = 130;  // upper bound with one spare cycle per transfer
  localparam int MAX_CYCLES  = 2 * (BUS_OPS * 4 + DP_ROUNDS * DP_CYCLES + 2 * SAT_CYCLES
                                    + LOOP_CYCLES + DP_CYCLES + 20);

  logic          adc_clk;
  logic          rst_n_i;
  logic [SW-1:0] adc_dat_a_i, adc_dat_b_i;
  logic [SW-1:0] dac_dat_a_o, dac_dat_b_o;
  logic [7:0]    led_o;
  logic [31:0]   sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic          sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;

  int seed      = 32'h4d21c2e2;
  int pin_mode  = 0;  // 0 zero, 1 random, 2 full scale only
  int cycle_cnt = 0;
  int bus_errs  = 0;
  int err_cnt, chk_cnt;
  int errs_before = 0;
  int tests_ok    = 0;
  int tests_bad   = 0;

  initial adc_clk = 1'b0;
  always #2 adc_clk = ~adc_clk;

  always @(posedge adc_clk)
    cycle_cnt <= cycle_cnt + 1;

  analog_top #(.SAMPLE_W(SW)) UUT (
    .adc_clk     (adc_clk),     .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),   .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),   .sys_err_o (sys_err_o)
  );

  tb_checker #(.SW(SW)) chk (
    .adc_clk  (adc_clk),     .rst_n_i (rst_n_i),
    .pin_a_i  (adc_dat_a_i), .pin_b_i (adc_dat_b_i),
    .dac_a_i  (dac_dat_a_o), .dac_b_i (dac_dat_b_o), .led_i (led_o),
    .addr_i   (sys_addr_i),  .wdata_i (sys_wdata_i),
    .wen_i    (sys_wen_i),   .ren_i   (sys_ren_i),
    .rdata_i  (sys_rdata_o), .ack_i   (sys_ack_o),   .err_i (sys_err_o),
    .err_cnt_o (err_cnt),    .chk_cnt_o (chk_cnt)
  );

  // new ADC codes every cycle
  always @(posedge adc_clk)
  begin : drive_pins
    logic [31:0] r;
    r = $random(seed);
    case (pin_mode)
      1:
      begin
        adc_dat_a_i <= r[SW-1:0];
        adc_dat_b_i <= r[2*SW-1:SW];
      end
      2:
      begin
        adc_dat_a_i <= {SW{r[0]}};  // all zero is +max, all ones -max
        adc_dat_b_i <= {SW{r[1]}};
      end
      default:
      begin
        adc_dat_a_i <= '0;
        adc_dat_b_i <= '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] reg_addr(input int region, input logic [19:0] ofs);
    return {9'h0, 3'(region), ofs};
  endfunction

  task automatic bus_cycle(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;  // one cycle strobe
    sys_ren_i <= 1'b0;
    do
    begin
      @(posedge adc_clk);
      waited++;
    end
    while (!sys_ack_o && waited < 8);
    if (!sys_ack_o)
    begin
      bus_errs++;
      $display("no ack from the register bus for address %h", addr);
    end
  endtask

  task automatic write_reg(input int region, input logic [19:0] ofs, input logic [31:0] data);
    bus_cycle(1'b1, reg_addr(region, ofs), data);
  endtask

  task automatic read_reg(input int region, input logic [19:0] ofs);
    bus_cycle(1'b0, reg_addr(region, ofs), 32'h0);
  endtask

  task automatic end_test(input string name);
    int errs;
    repeat (3) @(posedge adc_clk);  // drain the analog pipeline
    @(negedge adc_clk);
    errs        = err_cnt + bus_errs - errs_before;
    errs_before = err_cnt + bus_errs;
    if (errs == 0)
    begin
      tests_ok++;
      $display("test %-10s ok, %0d checks so far", name, chk_cnt);
    end
    else
    begin
      tests_bad++;
      $display("test %-10s failed with %0d errors", name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    logic [19:0] bad;
    rst_n_i     = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (5) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge adc_clk);
    end_test("reset");

    read_reg(HK, bus_pkg::HK_ID_OFS);
    repeat (12)
    begin
      r = $random(seed);
      write_reg(HK, bus_pkg::HK_LED_OFS, r);
      read_reg(HK, bus_pkg::HK_LED_OFS);
    end
    r = $random(seed);
    write_reg(OF, bus_pkg::OFS_A_OFS, r);  // upper bits ignored
    read_reg(OF, bus_pkg::OFS_A_OFS);
    r = $random(seed);
    write_reg(OF, bus_pkg::OFS_B_OFS, r);
    read_reg(OF, bus_pkg::OFS_B_OFS);
    read_reg(HK, bus_pkg::HK_CTRL_OFS);
    end_test("registers");

    pin_mode <= 1;
    repeat (DP_ROUNDS)
    begin
      r = $random(seed);
      write_reg(OF, bus_pkg::OFS_A_OFS, r);
      r = $random(seed);
      write_reg(OF, bus_pkg::OFS_B_OFS, r);
      repeat (DP_CYCLES) @(posedge adc_clk);
      read_reg(OF, bus_pkg::ADC_A_OFS);
      read_reg(OF, bus_pkg::ADC_B_OFS);
    end
    end_test("datapath");

    // full scale pins against full scale offsets
    pin_mode <= 2;
    write_reg(OF, bus_pkg::OFS_A_OFS, 32'h0000_1FFF);
    write_reg(OF, bus_pkg::OFS_B_OFS, 32'hFFFF_E000);
    repeat (SAT_CYCLES) @(posedge adc_clk);
    write_reg(OF, bus_pkg::OFS_A_OFS, 32'hFFFF_E000);
    write_reg(OF, bus_pkg::OFS_B_OFS, 32'h0000_1FFF);
    repeat (SAT_CYCLES) @(posedge adc_clk);
    end_test("saturation");

    pin_mode <= 1;
    for (int rg = 2; rg < bus_pkg::N_REGIONS; rg++)
    begin
      r = $random(seed);
      bus_cycle(1'b0, reg_addr(rg, r[19:0]) | {r[31:23], 23'h0}, 32'h0);
      bus_cycle(1'b1, reg_addr(rg, r[19:0]), r);
    end
    repeat (3)
    begin
      r   = $random(seed);
      bad = {6'h0, r[11:0], 2'b00} + 20'h10;  // past the last register
      write_reg(HK, bad, r);
      read_reg(HK, bad);
      write_reg(OF, bad, r);
      read_reg(OF, bad);
    end
    read_reg(HK, bus_pkg::HK_LED_OFS);
    read_reg(OF, bus_pkg::OFS_A_OFS);
    read_reg(OF, bus_pkg::OFS_B_OFS);
    end_test("bus errors");

    write_reg(OF, bus_pkg::OFS_A_OFS, 32'd100);
    write_reg(OF, bus_pkg::OFS_B_OFS, 32'hFFFF_FFB3);  // -77
    write_reg(HK, bus_pkg::HK_CTRL_OFS, 32'h1);
    repeat (LOOP_CYCLES) @(posedge adc_clk);
    write_reg(HK, bus_pkg::HK_CTRL_OFS, 32'h0);
    repeat (DP_CYCLES) @(posedge adc_clk);
    end_test("loopback");

    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, chk_cnt, err_cnt + bus_errs);
    if (tests_bad == 0 && err_cnt + bus_errs == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: test/tb_checker.sv
// samples every DUT port on the rising edge; the bus master must hold the address until ack
`timescale 1ns/1ps

module tb_checker
#(
  parameter int SW = 14
)
(
  input  logic          adc_clk,
  input  logic          rst_n_i,
  input  logic [SW-1:0] pin_a_i,    // ADC pin codes as driven
  input  logic [SW-1:0] pin_b_i,
  input  logic [SW-1:0] dac_a_i,    // DAC pin codes from the DUT
  input  logic [SW-1:0] dac_b_i,
  input  logic [7:0]    led_i,
  input  logic [31:0]   addr_i,
  input  logic [31:0]   wdata_i,
  input  logic          wen_i,
  input  logic          ren_i,
  input  logic [31:0]   rdata_i,
  input  logic          ack_i,
  input  logic          err_i,
  output int            err_cnt_o,
  output int            chk_cnt_o
);

  // model state
  logic [SW-1:0]        raw_a, raw_b;     // front end input registers
  logic signed [SW-1:0] fb_a, fb_b;       // registered DAC samples
  logic signed [SW-1:0] ofs_a, ofs_b;
  logic signed [SW-1:0] smp_a, smp_b;     // front end output this cycle
  logic [SW-1:0]        dac_a, dac_b;     // expected pin codes
  logic [7:0]           led;
  logic                 loop_en;
  logic                 valid = 1'b0;     // first reset edge seen
  logic                 pend = 1'b0;      // answer due at the next edge
  logic                 pend_err;
  logic                 known;
  logic [31:0]          pend_rdata, pend_addr;
  int                   errs = 0;
  int                   checks = 0;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  // flipping all bits below the top one maps pin code to two's complement and back
  function automatic logic [SW-1:0] flip(input logic [SW-1:0] c);
    return c ^ {1'b0, {(SW-1){1'b1}}};
  endfunction

  function automatic logic signed [SW-1:0] clip(input int s);
    int hi;
    int lo;
    hi = (1 << (SW-1)) - 1;
    lo = -(1 << (SW-1));
    if (s > hi)
      s = hi;
    if (s < lo)
      s = lo;
    return SW'(s);
  endfunction

  function automatic logic [31:0] widen(input logic signed [SW-1:0] v);
    return {{(32-SW){v[SW-1]}}, v};
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errs++;
      $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare, then step the model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin
    if (valid)
    begin
      expect_eq("dac_dat_a_o", 32'(dac_a_i), 32'(dac_a));
      expect_eq("dac_dat_b_o", 32'(dac_b_i), 32'(dac_b));
      expect_eq("led_o", 32'(led_i), 32'(led));
      if (pend && !ack_i)
      begin
        errs++;
        $display("missing ack one cycle after the strobe to address %h", pend_addr);
      end
      else if (pend)
      begin
        expect_eq("sys_rdata_o", rdata_i, pend_rdata);
        expect_eq("sys_err_o", 32'(err_i), 32'(pend_err));
      end
      else if (ack_i || err_i)
      begin
        errs++;
        $display("ack or err seen with no bus strobe outstanding at %0t", $time);
      end
    end
    pend = 1'b0;
    if (!rst_n_i)
    begin
      raw_a   = '0;
      raw_b   = '0;
      fb_a    = '0;
      fb_b    = '0;
      ofs_a   = '0;
      ofs_b   = '0;
      dac_a   = analog_pkg::DAC_RESET_CODE;
      dac_b   = analog_pkg::DAC_RESET_CODE;
      led     = 8'h0;
      loop_en = 1'b0;
      valid   = 1'b1;
    end
    else
    begin
      smp_a = loop_en ? fb_a : flip(raw_a);  // pre-edge sample
      smp_b = loop_en ? fb_b : flip(raw_b);
      fb_a  = clip(int'(smp_a) + int'(ofs_a));
      fb_b  = clip(int'(smp_b) + int'(ofs_b));
      dac_a = flip(fb_a);
      dac_b = flip(fb_b);
      if (wen_i || ren_i)
      begin
        pend       = 1'b1;
        pend_addr  = addr_i;
        pend_rdata = '0;
        known      = 1'b1;  // empty regions always answer clean
        if (addr_i[22:20] == 3'(bus_pkg::REGION_HK))
        begin
          case (addr_i[19:0])
            bus_pkg::HK_ID_OFS:   pend_rdata = bus_pkg::BOARD_ID;
            bus_pkg::HK_LED_OFS:  pend_rdata = {24'h0, led};
            bus_pkg::HK_CTRL_OFS: pend_rdata = {31'h0, loop_en};
            default:              known = 1'b0;
          endcase
          if (wen_i && addr_i[19:0] == bus_pkg::HK_LED_OFS)
            led = wdata_i[7:0];
          if (wen_i && addr_i[19:0] == bus_pkg::HK_CTRL_OFS)
            loop_en = wdata_i[0];
        end
        else if (addr_i[22:20] == 3'(bus_pkg::REGION_OFFSET))
        begin
          case (addr_i[19:0])
            bus_pkg::OFS_A_OFS: pend_rdata = widen(ofs_a);
            bus_pkg::OFS_B_OFS: pend_rdata = widen(ofs_b);
            bus_pkg::ADC_A_OFS: pend_rdata = widen(smp_a);  // snapshot at strobe
            bus_pkg::ADC_B_OFS: pend_rdata = widen(smp_b);
            default:            known = 1'b0;
          endcase
          if (wen_i && addr_i[19:0] == bus_pkg::OFS_A_OFS)
            ofs_a = wdata_i[SW-1:0];
          if (wen_i && addr_i[19:0] == bus_pkg::OFS_B_OFS)
            ofs_b = wdata_i[SW-1:0];
        end
        if (wen_i || !known)
          pend_rdata = '0;  // writes and errors return zero
        pend_err = ~known;
      end
      raw_a = pin_a_i;
      raw_b = pin_b_i;
    end
  end

endmodule

// File: design/analog_top.sv
// single clock adc_clk drives bus and analog path; one DAC port per channel, no DDR interleave
`timescale 1ns/1ps

module analog_top
#(
  parameter int SAMPLE_W = analog_pkg::SAMPLE_W
)
(
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  logic [SAMPLE_W-1:0]        adc_dat_a_i,
  input  logic [SAMPLE_W-1:0]        adc_dat_b_i,
  output logic [SAMPLE_W-1:0]        dac_dat_a_o,
  output logic [SAMPLE_W-1:0]        dac_dat_b_o,
  output logic [7:0]                 led_o,
  input  logic [bus_pkg::BUS_AW-1:0] sys_addr_i,
  input  logic [bus_pkg::BUS_DW-1:0] sys_wdata_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [bus_pkg::BUS_DW-1:0] sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o
);

  localparam int N  = bus_pkg::N_REGIONS;
  localparam int HK = bus_pkg::REGION_HK;
  localparam int OF = bus_pkg::REGION_OFFSET;

  // per region bus
  logic [N-1:0]                      slv_wen, slv_ren, slv_ack, slv_err;
  logic [N-1:0][bus_pkg::BUS_DW-1:0] slv_rdata;

  // analog path
  logic signed [SAMPLE_W-1:0] adc_a, adc_b;
  logic signed [SAMPLE_W-1:0] dac_loop_a, dac_loop_b;
  logic signed [SAMPLE_W-1:0] offset_a, offset_b;
  logic                       digital_loop;

  ////////////////////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_bus (
    .adc_clk     (adc_clk),     .rst_n_i    (rst_n_i),
    .sys_addr_i  (sys_addr_i),  .sys_wen_i  (sys_wen_i),  .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o  (sys_ack_o),  .sys_err_o (sys_err_o),
    .slv_wen_o   (slv_wen),     .slv_ren_o  (slv_ren),
    .slv_rdata_i (slv_rdata),   .slv_ack_i  (slv_ack),    .slv_err_i (slv_err)
  );

  // empty regions are tied off and answered by the decoder
  for (genvar r = 0; r < N; r++)
  begin : g_empty
    if (r != HK && r != OF)
    begin : g_tie
      assign slv_rdata[r] = '0;
      assign slv_ack[r]   = 1'b0;
      assign slv_err[r]   = 1'b0;
    end
  end

  housekeeping_regs i_hk (
    .adc_clk     (adc_clk),       .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (slv_wen[HK]),   .sys_ren_i   (slv_ren[HK]),
    .sys_rdata_o (slv_rdata[HK]), .sys_ack_o   (slv_ack[HK]), .sys_err_o (slv_err[HK]),
    .led_o       (led_o),
    .digital_loop_o (digital_loop)
  );

  output_offset_regs i_ofs (
    .adc_clk     (adc_clk),       .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (slv_wen[OF]),   .sys_ren_i   (slv_ren[OF]),
    .sys_rdata_o (slv_rdata[OF]), .sys_ack_o   (slv_ack[OF]), .sys_err_o (slv_err[OF]),
    .adc_a_i     (adc_a),         .adc_b_i     (adc_b),
    .offset_a_o  (offset_a),      .offset_b_o  (offset_b)
  );

  ////////////////////////////////////////////////////////////////////////////
  // analog path
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend #(.SAMPLE_W(SAMPLE_W)) i_adc (
    .adc_clk        (adc_clk),     .rst_n_i      (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i), .adc_dat_b_i  (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_loop_a_i   (dac_loop_a),  .dac_loop_b_i (dac_loop_b),
    .adc_a_o        (adc_a),       .adc_b_o      (adc_b)
  );

  dac_backend #(.SAMPLE_W(SAMPLE_W)) i_dac (
    .adc_clk      (adc_clk),     .rst_n_i      (rst_n_i),
    .adc_a_i      (adc_a),       .adc_b_i      (adc_b),
    .offset_a_i   (offset_a),    .offset_b_i   (offset_b),
    .dac_dat_a_o  (dac_dat_a_o), .dac_dat_b_o  (dac_dat_b_o),
    .dac_loop_a_o (dac_loop_a),  .dac_loop_b_o (dac_loop_b)
  );

endmodule

// File: design/output_offset_regs.sv
// region 1 slave; offsets take the low 14 write bits, ADC words are read only snapshots
`timescale 1ns/1ps

module output_offset_regs
(
  input  logic                                  adc_clk,
  input  logic                                  rst_n_i,
  input  logic [bus_pkg::BUS_AW-1:0]            sys_addr_i,
  input  logic [bus_pkg::BUS_DW-1:0]            sys_wdata_i,
  input  logic                                  sys_wen_i,
  input  logic                                  sys_ren_i,
  output logic [bus_pkg::BUS_DW-1:0]            sys_rdata_o,
  output logic                                  sys_ack_o,
  output logic                                  sys_err_o,
  input  logic signed [analog_pkg::SAMPLE_W-1:0] adc_a_i,     // current front end sample
  input  logic signed [analog_pkg::SAMPLE_W-1:0] adc_b_i,
  output logic signed [analog_pkg::SAMPLE_W-1:0] offset_a_o,
  output logic signed [analog_pkg::SAMPLE_W-1:0] offset_b_o
);

  localparam int SW = analog_pkg::SAMPLE_W;
  localparam int DW = bus_pkg::BUS_DW;

  bus_pkg::sys_addr_u addr;
  logic               hit;
  logic [DW-1:0]      rd_val;

  // sign extend a sample to a bus word
  function automatic logic [DW-1:0] sext(input logic signed [SW-1:0] v);
    return DW'(v);
  endfunction

  assign addr.raw = sys_addr_i;

  ////////////////////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (addr.fields.offset)
      bus_pkg::OFS_A_OFS: rd_val = sext(offset_a_o);
      bus_pkg::OFS_B_OFS: rd_val = sext(offset_b_o);
      bus_pkg::ADC_A_OFS: rd_val = sext(adc_a_i);  // sampled at the strobe
      bus_pkg::ADC_B_OFS: rd_val = sext(adc_b_i);
      default:            hit    = 1'b0;
    endcase
  end

  // offset writes
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      offset_a_o <= '0;
      offset_b_o <= '0;
    end
    else if (sys_wen_i)
    begin
      if (addr.fields.offset == bus_pkg::OFS_A_OFS)
        offset_a_o <= sys_wdata_i[SW-1:0];
      if (addr.fields.offset == bus_pkg::OFS_B_OFS)
        offset_b_o <= sys_wdata_i[SW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus answer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;
    end
  end

  always_ff @(posedge adc_clk)
    sys_rdata_o <= (sys_ren_i && hit) ? rd_val : '0;  // snapshot here

endmodule

// File: design/housekeeping_regs.sv
// region 0 slave; full words only, ID is read only and writes to it are acked and dropped
`timescale 1ns/1ps

module housekeeping_regs
(
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  logic [bus_pkg::BUS_AW-1:0] sys_addr_i,
  input  logic [bus_pkg::BUS_DW-1:0] sys_wdata_i,
  input  logic                       sys_wen_i,
  input  logic                       sys_ren_i,
  output logic [bus_pkg::BUS_DW-1:0] sys_rdata_o,
  output logic                       sys_ack_o,
  output logic                       sys_err_o,
  output logic [7:0]                 led_o,
  output logic                       digital_loop_o
);

  bus_pkg::sys_addr_u         addr;
  logic                       hit;     // offset is a known register
  logic [bus_pkg::BUS_DW-1:0] rd_val;

  assign addr.raw = sys_addr_i;

  ////////////////////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (addr.fields.offset)
      bus_pkg::HK_ID_OFS:   rd_val = bus_pkg::BOARD_ID;
      bus_pkg::HK_LED_OFS:  rd_val = {24'h0, led_o};
      bus_pkg::HK_CTRL_OFS: rd_val = {31'h0, digital_loop_o};
      default:              hit    = 1'b0;
    endcase
  end

  // register writes
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      led_o          <= 8'h0;
      digital_loop_o <= 1'b0;
    end
    else if (sys_wen_i)
    begin
      if (addr.fields.offset == bus_pkg::HK_LED_OFS)
        led_o <= sys_wdata_i[7:0];
      if (addr.fields.offset == bus_pkg::HK_CTRL_OFS)
        digital_loop_o <= sys_wdata_i[0];  // loopback enable
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus answer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;            // always one cycle
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;   // unknown offset
    end
  end

  // zero unless a valid read
  always_ff @(posedge adc_clk)
    sys_rdata_o <= (sys_ren_i && hit) ? rd_val : '0;

endmodule

// File: design/dac_backend.sv
// sum of sample and offset saturates at full scale, no wrap; pins show the value one cycle later
`timescale 1ns/1ps

module dac_backend
#(
  parameter int SAMPLE_W = analog_pkg::SAMPLE_W
)
(
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  logic signed [SAMPLE_W-1:0] adc_a_i,
  input  logic signed [SAMPLE_W-1:0] adc_b_i,
  input  logic signed [SAMPLE_W-1:0] offset_a_i,
  input  logic signed [SAMPLE_W-1:0] offset_b_i,
  output logic [SAMPLE_W-1:0]        dac_dat_a_o,   // pin code CH1
  output logic [SAMPLE_W-1:0]        dac_dat_b_o,   // pin code CH2
  output logic signed [SAMPLE_W-1:0] dac_loop_a_o,  // back to the front end
  output logic signed [SAMPLE_W-1:0] dac_loop_b_o
);

  localparam int SUM_W = analog_pkg::SUM_W;

  logic signed [SUM_W-1:0]    sum_a, sum_b;  // one guard bit
  logic signed [SAMPLE_W-1:0] sat_a, sat_b;

  // clip to full scale when the two top bits differ
  function automatic logic signed [SAMPLE_W-1:0] sat(input logic signed [SUM_W-1:0] s);
    if (s[SUM_W-1] ^ s[SUM_W-2])
      return {s[SUM_W-1], {(SAMPLE_W-1){~s[SUM_W-1]}}};  // most neg or most pos
    return s[SAMPLE_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // offset and saturation
  ////////////////////////////////////////////////////////////////////////////

  assign sum_a = adc_a_i + offset_a_i;  // both sign extended
  assign sum_b = adc_b_i + offset_b_i;

  assign sat_a = sat(sum_a);
  assign sat_b = sat(sum_b);

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_loop_a_o <= '0;
      dac_loop_b_o <= '0;
      dac_dat_a_o  <= analog_pkg::DAC_RESET_CODE;  // mid scale
      dac_dat_b_o  <= analog_pkg::DAC_RESET_CODE;
    end
    else
    begin
      dac_loop_a_o <= sat_a;
      dac_loop_b_o <= sat_b;
      dac_dat_a_o  <= analog_pkg::conv_code(sat_a);  // back to negative slope
      dac_dat_b_o  <= analog_pkg::conv_code(sat_b);
    end
  end

endmodule

// File: design/adc_frontend.sv
// one register stage on the pins; loopback samples bypass it and are taken as they come
`timescale 1ns/1ps

module adc_frontend
#(
  parameter int SAMPLE_W = analog_pkg::SAMPLE_W
)
(
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  logic [SAMPLE_W-1:0]        adc_dat_a_i,     // pin code CH1
  input  logic [SAMPLE_W-1:0]        adc_dat_b_i,     // pin code CH2
  input  logic                       digital_loop_i,
  input  logic signed [SAMPLE_W-1:0] dac_loop_a_i,    // registered DAC sample
  input  logic signed [SAMPLE_W-1:0] dac_loop_b_i,
  output logic signed [SAMPLE_W-1:0] adc_a_o,
  output logic signed [SAMPLE_W-1:0] adc_b_o
);

  logic [SAMPLE_W-1:0] adc_raw_a_q;  // pin code as captured
  logic [SAMPLE_W-1:0] adc_raw_b_q;

  ////////////////////////////////////////////////////////////////////////////
  // input registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_raw_a_q <= '0;
      adc_raw_b_q <= '0;
    end
    else
    begin
      adc_raw_a_q <= adc_dat_a_i;
      adc_raw_b_q <= adc_dat_b_i;
    end
  end

  // negative slope to two's complement, or the DAC sample in loopback
  assign adc_a_o = digital_loop_i ? dac_loop_a_i
                                  : $signed(analog_pkg::conv_code(adc_raw_a_q));
  assign adc_b_o = digital_loop_i ? dac_loop_b_i
                                  : $signed(analog_pkg::conv_code(adc_raw_b_q));

endmodule

// File: design/sys_bus_decoder.sv
// address must be held until ack; only regions 0 and 1 are populated, the others answer zero
`timescale 1ns/1ps

module sys_bus_decoder
(
  input  logic                                           adc_clk,
  input  logic                                           rst_n_i,
  input  logic [bus_pkg::BUS_AW-1:0]                     sys_addr_i,
  input  logic                                           sys_wen_i,    // one cycle pulse
  input  logic                                           sys_ren_i,    // one cycle pulse
  output logic [bus_pkg::BUS_DW-1:0]                     sys_rdata_o,
  output logic                                           sys_ack_o,
  output logic                                           sys_err_o,
  output logic [bus_pkg::N_REGIONS-1:0]                  slv_wen_o,
  output logic [bus_pkg::N_REGIONS-1:0]                  slv_ren_o,
  input  logic [bus_pkg::N_REGIONS-1:0][bus_pkg::BUS_DW-1:0] slv_rdata_i,
  input  logic [bus_pkg::N_REGIONS-1:0]                  slv_ack_i,
  input  logic [bus_pkg::N_REGIONS-1:0]                  slv_err_i
);

  localparam int N = bus_pkg::N_REGIONS;

  // regions with a real slave behind them
  localparam logic [N-1:0] REGION_USED = (1 << bus_pkg::REGION_HK)
                                       | (1 << bus_pkg::REGION_OFFSET);

  bus_pkg::sys_addr_u addr;
  logic [N-1:0]       cs;           // one-hot region select
  logic               region_used;  // addressed region has a slave
  logic               empty_ack_q;  // own answer for empty regions

  assign addr.raw = sys_addr_i;
  assign cs       = {{(N-1){1'b0}}, 1'b1} << addr.fields.region;

  assign slv_wen_o = cs & {N{sys_wen_i}};
  assign slv_ren_o = cs & {N{sys_ren_i}};

  ////////////////////////////////////////////////////////////////////////////
  // answer multiplexer
  ////////////////////////////////////////////////////////////////////////////

  assign region_used = |(cs & REGION_USED);

  assign sys_rdata_o = region_used ? slv_rdata_i[addr.fields.region] : '0;
  assign sys_ack_o   = |(cs & REGION_USED & slv_ack_i) | empty_ack_q;
  assign sys_err_o   = |(cs & REGION_USED & slv_err_i);  // empty regions never flag

  // empty regions ack one cycle after the strobe like a slave would
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      empty_ack_q <= 1'b0;
    else
      empty_ack_q <= (sys_wen_i | sys_ren_i) & ~region_used;
  end

endmodule

// File: design/bus_pkg.sv
// register bus of 32-bit words only; no byte selects, address bits 22:20 pick one of 8 regions
package bus_pkg;

  localparam int BUS_AW = 32;  // address width
  localparam int BUS_DW = 32;  // data width

  // flat address or region plus offset
  typedef union packed {
    logic [BUS_AW-1:0] raw;
    struct packed {
      logic [8:0]  unused;   // bits 31:23 not decoded
      logic [2:0]  region;   // bits 22:20
      logic [19:0] offset;   // register offset in region
    } fields;
  } sys_addr_u;

  ////////////////////////////////////////////////////////////////////////////
  // regions and registers
  ////////////////////////////////////////////////////////////////////////////

  localparam int N_REGIONS     = 8;
  localparam int REGION_HK     = 0;  // housekeeping
  localparam int REGION_OFFSET = 1;  // DAC offsets and ADC readback

  // housekeeping
  localparam logic [19:0] HK_ID_OFS   = 20'h0;
  localparam logic [19:0] HK_LED_OFS  = 20'h4;
  localparam logic [19:0] HK_CTRL_OFS = 20'h8;  // bit 0 digital loopback

  // output offset block
  localparam logic [19:0] OFS_A_OFS = 20'h0;
  localparam logic [19:0] OFS_B_OFS = 20'h4;
  localparam logic [19:0] ADC_A_OFS = 20'h8;  // read only
  localparam logic [19:0] ADC_B_OFS = 20'hC;  // read only

  localparam logic [BUS_DW-1:0] BOARD_ID = 32'hA5A1_0014;

endpackage

// File: design/analog_pkg.sv
// two's complement samples of 14 bits; pins assumed negative-slope offset binary on both converters
package analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W = 14;            // ADC and DAC resolution
  localparam int SUM_W    = SAMPLE_W + 1;  // one guard bit for sample plus offset

  // pin code of a zero sample
  localparam logic [SAMPLE_W-1:0] DAC_RESET_CODE = 14'h1FFF;

  ////////////////////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////////////////////

  // keep the top bit and flip the rest
  // same rule in both directions so one function serves ADC and DAC
  function automatic logic [SAMPLE_W-1:0] conv_code(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage
